//--- include/clk_mux_defs.svh
`ifndef CLK_MUX_DEFS_SVH
`define CLK_MUX_DEFS_SVH

// Measurement window of the rate monitor, in clk_int cycles
`define CLK_MUX_WINDOW_CYCLES 64

// Fewer edges than this in one window means clk_ext has stopped
`define CLK_MUX_MIN_EDGES 4

// Synthesizer reset pulse length after a source change
`define CLK_MUX_RESET_CYCLES 8

// Flops per synchronizer chain
`define CLK_MUX_SYNC_STAGES 2

`endif

//--- design/clk_mux_reg_pkg.sv
`default_nettype none

package clk_mux_reg_pkg;

    // Register map, one 32-bit word per address
    typedef enum logic [1:0] {
        CTRL     = 2'd0,
        STATUS   = 2'd1,
        RATE     = 2'd2,
        SWITCHES = 2'd3
    } reg_addr_e;

    // Single-cycle strobe port, no back-pressure
    typedef struct packed {
        logic        wr_stb;
        logic        rd_stb;
        reg_addr_e   addr;
        logic [31:0] wdata;
    } reg_req_t;

    typedef struct packed {
        logic        rd_valid;
        logic [31:0] rdata;
    } reg_rsp_t;

    typedef struct packed {
        logic [30:0] reserved;
        logic        int_select;
    } ctrl_t;

    typedef struct packed {
        logic [28:0] reserved;
        logic        sel_ext;
        logic        locked;
        logic        ext_active;
    } status_t;

    // One register word, seen as raw bits or through either layout
    typedef union packed {
        logic [31:0] raw;
        ctrl_t       ctrl;
        status_t     status;
    } reg_word_u;

endpackage

`default_nettype wire

//--- design/clk_mux_mon_pkg.sv
`default_nettype none

package clk_mux_mon_pkg;

    // Edges of clk_ext counted in one window
    typedef logic [23:0] rate_t;

    // Everything the result stage reports from the execute stage
    typedef struct packed {
        rate_t       rate;
        logic        ext_active;
        logic        sel_ext;
        logic        locked;
        logic [15:0] switches;
    } mon_status_t;

endpackage

`default_nettype wire

//--- design/clk_reg_decode.sv
`timescale 1ns/1ps
`default_nettype none

module clk_reg_decode (
    input  wire                              clk_int,
    input  wire                              rst_n,
    input  wire clk_mux_reg_pkg::reg_req_t   reg_req,
    output clk_mux_reg_pkg::ctrl_t           ctrl,
    output logic                             rd_stb,
    output clk_mux_reg_pkg::reg_addr_e       rd_addr
);

    logic ctrl_wr;

    // Only CTRL is writable, the other addresses are read-only
    assign ctrl_wr = reg_req.wr_stb && (reg_req.addr == clk_mux_reg_pkg::CTRL);

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '0;
        end else if (ctrl_wr) begin
            // Unused bits are kept at zero whatever was written
            ctrl.reserved   <= '0;
            ctrl.int_select <= reg_req.wdata[0];
        end
    end

    // Read requests go straight on; the result stage registers the word
    // so rd_valid lands one cycle after the strobe
    always_comb begin
        rd_stb  = reg_req.rd_stb;
        rd_addr = reg_req.addr;
    end

    // The port never carries a read and a write in the same cycle
    a_no_rd_wr_overlap: assert property (
        @(posedge clk_int) disable iff (!rst_n)
        !(reg_req.wr_stb && reg_req.rd_stb)
    );

endmodule

`default_nettype wire

//--- design/clk_rate_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "clk_mux_defs.svh"

module clk_rate_monitor (
    input  wire                      clk_int,
    input  wire                      rst_n,
    input  wire                      clk_ext,
    output clk_mux_mon_pkg::rate_t   rate,
    output logic                     ext_active
);

    localparam int WIN_W = $clog2(`CLK_MUX_WINDOW_CYCLES);

    logic [`CLK_MUX_SYNC_STAGES-1:0] ext_sync;
    logic                            ext_prev;
    logic                            ext_rise;
    logic [WIN_W-1:0]                win_cnt;
    logic                            win_last;
    clk_mux_mon_pkg::rate_t          edge_cnt;
    clk_mux_mon_pkg::rate_t          win_total;

    // clk_ext is asynchronous to clk_int
    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            ext_sync <= '0;
            ext_prev <= 1'b0;
        end else begin
            ext_sync <= {ext_sync[`CLK_MUX_SYNC_STAGES-2:0], clk_ext};
            ext_prev <= ext_sync[`CLK_MUX_SYNC_STAGES-1];
        end
    end

    assign ext_rise = ext_sync[`CLK_MUX_SYNC_STAGES-1] && !ext_prev;

    assign win_last = (win_cnt == WIN_W'(`CLK_MUX_WINDOW_CYCLES - 1));

    // Includes an edge that falls on the window's last cycle
    assign win_total = edge_cnt + clk_mux_mon_pkg::rate_t'(ext_rise);

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            win_cnt  <= '0;
            edge_cnt <= '0;
        end else begin
            win_cnt <= win_cnt + 1'b1;
            if (win_last) begin
                edge_cnt <= '0;
            end else begin
                edge_cnt <= win_total;
            end
        end
    end

    // Result of the finished window, held until the next one ends
    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            rate       <= '0;
            ext_active <= 1'b0;
        end else if (win_last) begin
            rate       <= win_total;
            ext_active <= (win_total >= clk_mux_mon_pkg::rate_t'(`CLK_MUX_MIN_EDGES));
        end
    end

    // A synchronized edge needs at least two clk_int cycles
    a_edge_cnt_bound: assert property (
        @(posedge clk_int) disable iff (!rst_n)
        edge_cnt <= clk_mux_mon_pkg::rate_t'(`CLK_MUX_WINDOW_CYCLES / 2)
    );

endmodule

`default_nettype wire

//--- design/clk_source_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "clk_mux_defs.svh"

module clk_source_select (
    input  wire                            clk_int,
    input  wire                            rst_n,
    input  wire                            ext_active,
    input  wire                            lock_in,
    input  wire clk_mux_reg_pkg::ctrl_t    ctrl,
    output logic                           mmcm_sel,
    output logic                           mmcm_reset,
    output logic                           locked,
    output logic [15:0]                    switches
);

    localparam int RST_W = $clog2(`CLK_MUX_RESET_CYCLES + 1);

    logic                            sel_next;
    logic                            sel_change;
    logic [RST_W-1:0]                rst_cnt;
    logic [`CLK_MUX_SYNC_STAGES-1:0] lock_sync;

    // External source only when it runs and the user has not forced internal
    assign sel_next   = ext_active && !ctrl.int_select;
    assign sel_change = (sel_next != mmcm_sel);

    // Counter starts full in reset, so the pulse covers reset and
    // RESET_CYCLES cycles after it
    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            mmcm_sel <= 1'b0;
            rst_cnt  <= RST_W'(`CLK_MUX_RESET_CYCLES);
        end else begin
            mmcm_sel <= sel_next;
            if (sel_change) begin
                rst_cnt <= RST_W'(`CLK_MUX_RESET_CYCLES);
            end else if (rst_cnt != '0) begin
                rst_cnt <= rst_cnt - 1'b1;
            end
        end
    end

    assign mmcm_reset = (rst_cnt != '0);

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            switches <= '0;
        end else if (sel_change && (switches != 16'hFFFF)) begin
            switches <= switches + 1'b1;
        end
    end

    // Lock pin comes from the synthesizer, asynchronous here
    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            lock_sync <= '0;
        end else begin
            lock_sync <= {lock_sync[`CLK_MUX_SYNC_STAGES-2:0], lock_in};
        end
    end

    assign locked = lock_sync[`CLK_MUX_SYNC_STAGES-1];

    // Every new source gets a full synthesizer reset pulse
    a_reset_on_switch: assert property (
        @(posedge clk_int) disable iff (!rst_n)
        $changed(mmcm_sel) |-> mmcm_reset [* `CLK_MUX_RESET_CYCLES]
    );

endmodule

`default_nettype wire

//--- design/clk_status_readback.sv
`timescale 1ns/1ps
`default_nettype none

module clk_status_readback (
    input  wire                                clk_int,
    input  wire                                rst_n,
    input  wire                                rd_stb,
    input  wire clk_mux_reg_pkg::reg_addr_e    rd_addr,
    input  wire clk_mux_reg_pkg::ctrl_t        ctrl,
    input  wire clk_mux_mon_pkg::mon_status_t  status,
    output clk_mux_reg_pkg::reg_rsp_t          reg_rsp
);

    clk_mux_reg_pkg::reg_word_u rd_word;
    logic                       rd_valid_q;
    logic [31:0]                rdata_q;

    always_comb begin
        rd_word.raw = '0;
        case (rd_addr)
            clk_mux_reg_pkg::CTRL: begin
                rd_word.ctrl = ctrl;
            end
            clk_mux_reg_pkg::STATUS: begin
                rd_word.status.ext_active = status.ext_active;
                rd_word.status.locked     = status.locked;
                rd_word.status.sel_ext    = status.sel_ext;
            end
            clk_mux_reg_pkg::RATE: begin
                rd_word.raw = 32'(status.rate);
            end
            clk_mux_reg_pkg::SWITCHES: begin
                rd_word.raw = 32'(status.switches);
            end
            default: begin
                rd_word.raw = '0;
            end
        endcase
    end

    always_ff @(posedge clk_int or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= rd_stb;
        end
    end

    // Data word only loads on a read, valid alongside rd_valid
    always_ff @(posedge clk_int) begin
        if (rd_stb) begin
            rdata_q <= rd_word.raw;
        end
    end

    always_comb begin
        reg_rsp.rd_valid = rd_valid_q;
        reg_rsp.rdata    = rdata_q;
    end

endmodule

`default_nettype wire

//--- design/clk_mux_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module clk_mux_ctrl (
    input  wire                              clk_int,
    input  wire                              rst_n,
    input  wire                              clk_ext,
    input  wire                              lock_in,
    input  wire clk_mux_reg_pkg::reg_req_t   reg_req,
    output clk_mux_reg_pkg::reg_rsp_t        reg_rsp,
    output logic                             mmcm_sel,
    output logic                             mmcm_reset
);

    clk_mux_reg_pkg::ctrl_t       ctrl;
    logic                         rd_stb;
    clk_mux_reg_pkg::reg_addr_e   rd_addr;
    clk_mux_mon_pkg::rate_t       rate;
    logic                         ext_active;
    logic                         locked;
    logic [15:0]                  switches;
    clk_mux_mon_pkg::mon_status_t mon_status;

    // Decode
    clk_reg_decode u_decode (
        .clk_int (clk_int),
        .rst_n   (rst_n),
        .reg_req (reg_req),
        .ctrl    (ctrl),
        .rd_stb  (rd_stb),
        .rd_addr (rd_addr)
    );

    // Execute
    clk_rate_monitor u_monitor (
        .clk_int    (clk_int),
        .rst_n      (rst_n),
        .clk_ext    (clk_ext),
        .rate       (rate),
        .ext_active (ext_active)
    );

    clk_source_select u_select (
        .clk_int    (clk_int),
        .rst_n      (rst_n),
        .ext_active (ext_active),
        .lock_in    (lock_in),
        .ctrl       (ctrl),
        .mmcm_sel   (mmcm_sel),
        .mmcm_reset (mmcm_reset),
        .locked     (locked),
        .switches   (switches)
    );

    // mmcm_sel is the registered sel_ext
    assign mon_status = '{
        rate:       rate,
        ext_active: ext_active,
        sel_ext:    mmcm_sel,
        locked:     locked,
        switches:   switches
    };

    // Result
    clk_status_readback u_readback (
        .clk_int (clk_int),
        .rst_n   (rst_n),
        .rd_stb  (rd_stb),
        .rd_addr (rd_addr),
        .ctrl    (ctrl),
        .status  (mon_status),
        .reg_rsp (reg_rsp)
    );

endmodule

`default_nettype wire

//--- verification/clk_mux_ctrl_tb.sv
`timescale 1ns/1ps

`include "clk_mux_defs.svh"

`default_nettype none

module clk_mux_ctrl_tb;

    localparam int TIMEOUT_CYCLES = 4000;
    // Edges per window with clk_int at 8 ns and clk_ext at 24 ns
    localparam int NOMINAL_RATE = `CLK_MUX_WINDOW_CYCLES * 8 / 24;

    logic                      clk_int;
    logic                      rst_n;
    logic                      clk_ext;
    logic                      lock_in;
    clk_mux_reg_pkg::reg_req_t reg_req;
    clk_mux_reg_pkg::reg_rsp_t reg_rsp;
    logic                      mmcm_sel;
    logic                      mmcm_reset;

    logic        ext_run;
    logic [15:0] lfsr_state;
    logic [15:0] exp_switches;
    logic        exp_sel;
    int          cycle_count = 0;

    clk_mux_ctrl UUT (
        .clk_int    (clk_int),
        .rst_n      (rst_n),
        .clk_ext    (clk_ext),
        .lock_in    (lock_in),
        .reg_req    (reg_req),
        .reg_rsp    (reg_rsp),
        .mmcm_sel   (mmcm_sel),
        .mmcm_reset (mmcm_reset)
    );

    initial begin
        clk_int = 1'b0;
        forever #4 clk_int = ~clk_int;
    end

    // Offset by 3 ns so clk_ext never toggles on a clk_int edge
    initial begin
        clk_ext = 1'b0;
        #3;
        forever begin
            #12;
            clk_ext = ext_run ? ~clk_ext : 1'b0;
        end
    end

    always @(posedge clk_int) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_error("Timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic random_word(output logic [31:0] word);
        for (int i = 0; i < 32; i++) begin
            word[i]    = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk_int);
            #1;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_word(input string name, input clk_mux_reg_pkg::reg_word_u got,
                              input clk_mux_reg_pkg::reg_word_u exp);
        if (got.raw !== exp.raw) begin
            report_error($sformatf("FAILED %s: got %h, expected %h", name, got.raw, exp.raw));
        end
    endtask

    task automatic check_rsp(input string name, input clk_mux_reg_pkg::reg_rsp_t got,
                             input clk_mux_reg_pkg::reg_rsp_t exp);
        if (got !== exp) begin
            report_error($sformatf(
                "FAILED %s: got rd_valid=%h rdata=%h, expected rd_valid=%h rdata=%h",
                name, got.rd_valid, got.rdata, exp.rd_valid, exp.rdata));
        end
    endtask

    task automatic write_reg(input clk_mux_reg_pkg::reg_addr_e addr, input logic [31:0] data);
        reg_req.wr_stb = 1'b1;
        reg_req.addr   = addr;
        reg_req.wdata  = data;
        step_cycles(1);
        reg_req = '0;
    endtask

    // rd_valid must be high in the cycle after the strobe and low after that
    task automatic read_reg(input clk_mux_reg_pkg::reg_addr_e addr,
                            output clk_mux_reg_pkg::reg_rsp_t rsp);
        reg_req.rd_stb = 1'b1;
        reg_req.addr   = addr;
        step_cycles(1);
        rsp = reg_rsp;
        check_bit("rd_valid", reg_rsp.rd_valid, 1'b1);
        reg_req = '0;
        step_cycles(1);
        check_bit("rd_valid", reg_rsp.rd_valid, 1'b0);
    endtask

    task automatic expect_reg(input string name, input clk_mux_reg_pkg::reg_addr_e addr,
                              input logic [31:0] exp_data);
        clk_mux_reg_pkg::reg_rsp_t rsp;
        clk_mux_reg_pkg::reg_rsp_t exp;
        read_reg(addr, rsp);
        exp.rd_valid = 1'b1;
        exp.rdata    = exp_data;
        check_rsp(name, rsp, exp);
    endtask

    // STATUS bits: 0 ext_active, 1 locked, 2 sel_ext
    task automatic expect_status(input logic ext_active, input logic locked, input logic sel_ext);
        clk_mux_reg_pkg::reg_rsp_t  rsp;
        clk_mux_reg_pkg::reg_word_u got;
        clk_mux_reg_pkg::reg_word_u exp;
        read_reg(clk_mux_reg_pkg::STATUS, rsp);
        got.raw = rsp.rdata;
        exp.raw = {29'd0, sel_ext, locked, ext_active};
        check_word("STATUS", got, exp);
    endtask

    // Writes CTRL and follows mmcm_sel and the reset pulse of the new choice
    task automatic apply_ctrl(input logic [31:0] data, input logic ext_running);
        logic old_sel;
        logic new_sel;
        old_sel = exp_sel;
        new_sel = ext_running && !data[0];
        write_reg(clk_mux_reg_pkg::CTRL, data);
        check_bit("mmcm_sel", mmcm_sel, old_sel);
        step_cycles(1);
        check_bit("mmcm_sel", mmcm_sel, new_sel);
        if (new_sel != old_sel) begin
            exp_switches = exp_switches + 16'd1;
            for (int i = 0; i < `CLK_MUX_RESET_CYCLES; i++) begin
                check_bit("mmcm_reset", mmcm_reset, 1'b1);
                step_cycles(1);
            end
        end
        exp_sel = new_sel;
        check_bit("mmcm_reset", mmcm_reset, 1'b0);
        expect_reg("CTRL", clk_mux_reg_pkg::CTRL, {31'd0, data[0]});
        expect_reg("SWITCHES", clk_mux_reg_pkg::SWITCHES, {16'd0, exp_switches});
    endtask

    task automatic test_reset();
        for (int i = 0; i < 16; i++) begin
            step_cycles(1);
            check_bit("mmcm_reset", mmcm_reset, 1'b1);
        end
        rst_n = 1'b1;
        for (int i = 0; i < `CLK_MUX_RESET_CYCLES; i++) begin
            check_bit("mmcm_reset", mmcm_reset, 1'b1);
            step_cycles(1);
        end
        check_bit("mmcm_reset", mmcm_reset, 1'b0);
        check_bit("mmcm_sel", mmcm_sel, 1'b0);
        expect_reg("CTRL", clk_mux_reg_pkg::CTRL, 32'd0);
        expect_status(1'b0, 1'b0, 1'b0);
        expect_reg("SWITCHES", clk_mux_reg_pkg::SWITCHES, 32'd0);
    endtask

    task automatic test_measurement();
        clk_mux_reg_pkg::reg_rsp_t rsp;
        step_cycles(3 * `CLK_MUX_WINDOW_CYCLES);
        read_reg(clk_mux_reg_pkg::RATE, rsp);
        if ((rsp.rdata < 32'(NOMINAL_RATE - 1)) || (rsp.rdata > 32'(NOMINAL_RATE + 1))) begin
            report_error($sformatf("FAILED RATE: got %h, expected %h plus or minus 1",
                                   rsp.rdata, NOMINAL_RATE));
        end
        expect_status(1'b1, 1'b0, 1'b1);
        exp_sel = 1'b1;
        check_bit("mmcm_sel", mmcm_sel, exp_sel);
        exp_switches = 16'd1;
        expect_reg("SWITCHES", clk_mux_reg_pkg::SWITCHES, {16'd0, exp_switches});
    endtask

    task automatic test_ctrl_write();
        logic [31:0] word;
        random_word(word);
        apply_ctrl(word, 1'b1);
        if (!word[0]) begin
            // Same word with int_select set so the switch to internal is covered
            apply_ctrl(word | 32'd1, 1'b1);
        end
        apply_ctrl(32'd0, 1'b1);
        check_bit("mmcm_sel", mmcm_sel, 1'b1);
    endtask

    task automatic test_clock_loss();
        ext_run = 1'b0;
        // Two windows plus the synchronizer and edge detect delay
        step_cycles(2 * `CLK_MUX_WINDOW_CYCLES + 4);
        expect_reg("RATE", clk_mux_reg_pkg::RATE, 32'd0);
        expect_status(1'b0, 1'b0, 1'b0);
        exp_sel = 1'b0;
        check_bit("mmcm_sel", mmcm_sel, exp_sel);
        exp_switches = exp_switches + 16'd1;
        expect_reg("SWITCHES", clk_mux_reg_pkg::SWITCHES, {16'd0, exp_switches});
    endtask

    task automatic test_lock();
        lock_in = 1'b1;
        step_cycles(3);
        expect_status(1'b0, 1'b1, 1'b0);
        lock_in = 1'b0;
        step_cycles(3);
        expect_status(1'b0, 1'b0, 1'b0);
    endtask

    initial begin
        rst_n        = 1'b0;
        lock_in      = 1'b0;
        reg_req      = '0;
        ext_run      = 1'b1;
        lfsr_state   = 16'd60006;
        exp_switches = 16'd0;
        exp_sel      = 1'b0;
        test_reset();
        test_measurement();
        test_ctrl_write();
        test_clock_loss();
        test_lock();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
design/clk_mux_reg_pkg.sv
design/clk_mux_mon_pkg.sv
design/clk_reg_decode.sv
design/clk_rate_monitor.sv
design/clk_source_select.sv
design/clk_status_readback.sv
design/clk_mux_ctrl.sv
verification/clk_mux_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the clk_mux_ctrl testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module clk_mux_ctrl_tb -o clk_mux_ctrl_sim
if [ $? -ne 0 ]; then
    echo "Verilator compilation failed"
    exit 1
fi

./obj_dir/clk_mux_ctrl_sim > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if ! grep -q "TEST OK" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0
